//--- include/buffer_pool_params.svh
// Sizing of the buffer pool, shared by the packages, the RTL and the testbench
// Include wherever buffer count or widths are needed

`ifndef BUFFER_POOL_PARAMS_SVH
`define BUFFER_POOL_PARAMS_SVH

// Number of buffers in the pool
`define BUF_COUNT 2

// Line address width, 512 lines per buffer
`define BUF_AW 9

// Stream and RAM word width
`define BUF_DW 32

`endif

//--- logic/buffer_ctrl_pkg.sv
// Host control word and per-buffer status types
// Imported by the buffer interface and the pool top level

`include "buffer_pool_params.svh"

package buffer_ctrl_pkg;

   // One host command, 32 bits, top bit first
   typedef struct packed {
      logic [3:0]         buf_num;    // Target buffer
      logic [2:0]         port;       // Routing field, not used here
      logic               clear;
      logic               write;
      logic               read;
      logic [3:0]         spare;
      logic [`BUF_AW-1:0] last_line;
      logic [`BUF_AW-1:0] first_line;
   } ctrl_word_t;

   // Levels reported per buffer, held until a clear
   typedef struct packed {
      logic done;
      logic error;
      logic idle;
   } buf_status_t;

endpackage

//--- logic/buffer_stream_pkg.sv
// Stream word types for the shared write and read paths
// The same beat layout is used in both directions

`include "buffer_pool_params.svh"

package buffer_stream_pkg;

   // Sideband flags carried with every word
   typedef struct packed {
      logic [1:0] occ;    // Occupancy of the last word
      logic       eop;
      logic       sop;
   } stream_flags_t;

   // One stream word with its flags
   typedef struct packed {
      logic [`BUF_DW-1:0] data;
      stream_flags_t      flags;
   } stream_beat_t;

endpackage

//--- logic/buffer_ram.sv
// Single-port synchronous RAM backing one packet buffer
// Read-first, one cycle read latency, output held while disabled

`include "buffer_pool_params.svh"

module buffer_ram
(
   input  logic              clk,
   input  logic              en_i,
   input  logic              we_i,
   input  logic [`BUF_AW-1:0] addr_i,
   input  logic [`BUF_DW-1:0] dat_i,
   output logic [`BUF_DW-1:0] dat_o
);

   localparam int DEPTH = 1 << `BUF_AW;

   logic [`BUF_DW-1:0] mem [DEPTH];

   // Old contents come out on a write cycle
   always_ff @(posedge clk)
   begin
      if (en_i)
      begin
         if (we_i)
         begin
            mem[addr_i] <= dat_i;
         end
         dat_o <= mem[addr_i];   // Holds when en_i is low
      end
   end

endmodule

//--- logic/buffer_int.sv
// Per-buffer control FSM, moves one packet between the streams and its RAM
// Started by a host control word whose buffer number matches BUF_NUM

`include "buffer_pool_params.svh"

module buffer_int
   import buffer_ctrl_pkg::*, buffer_stream_pkg::*;
#(
   parameter int BUF_NUM = 0
)
(
   input  logic               clk,
   input  logic               rst,

   // Host control
   input  ctrl_word_t         ctrl_word_i,
   input  logic               go_i,
   output buf_status_t        status_o,

   // RAM side
   output logic               en_o,
   output logic               we_o,
   output logic [`BUF_AW-1:0] addr_o,
   output logic [`BUF_DW-1:0] dat_to_buf_o,
   input  logic [`BUF_DW-1:0] dat_from_buf_i,

   // Write stream
   input  stream_beat_t       wr_beat_i,
   input  logic               wr_valid_i,
   output logic               wr_ready_o,

   // Read stream
   output stream_beat_t       rd_beat_o,
   output logic               rd_ready_o,
   input  logic               rd_take_i
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PRE_READ,
      ST_READING,
      ST_WRITING,
      ST_ERROR,
      ST_DONE
   } state_t;

   ctrl_word_t ctrl_q;
   logic       go_q;
   state_t     state;
   logic       rd_sop;
   logic       rd_eop;
   logic       wr_sop;
   logic       wr_eop;
   logic       wr_error;

   // Used by the read address check
   logic [`BUF_AW-1:0] rd_offset;
   logic [`BUF_AW:0]   rd_span;

   // Capture commands meant for this buffer only
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl_q <= '0;
         go_q   <= 1'b0;
      end
      else
      begin
         go_q <= go_i && (ctrl_word_i.buf_num == 4'(BUF_NUM));
         if (go_i && (ctrl_word_i.buf_num == 4'(BUF_NUM)))
         begin
            ctrl_q <= ctrl_word_i;
         end
      end
   end

   assign wr_sop   = wr_beat_i.flags.sop;
   assign wr_eop   = wr_beat_i.flags.eop;
   assign wr_error = wr_sop && wr_eop;   // Both flags on one word is malformed

   always_ff @(posedge clk)
   begin
      if (rst || ctrl_q.clear)
      begin
         state  <= ST_IDLE;
         rd_sop <= 1'b0;
         rd_eop <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (go_q && ctrl_q.read)
               begin
                  state <= ST_PRE_READ;
               end
               else if (go_q && ctrl_q.write)
               begin
                  state <= ST_WRITING;
               end
            ST_PRE_READ:
            begin
               state  <= ST_READING;
               rd_sop <= 1'b1;
               rd_eop <= (ctrl_q.first_line == ctrl_q.last_line);   // Single-line packet
            end
            ST_READING:
               if (rd_take_i)
               begin
                  rd_sop <= 1'b0;
                  if (rd_eop)
                  begin
                     state  <= ST_DONE;
                     rd_eop <= 1'b0;
                  end
                  else
                  begin
                     rd_eop <= (addr_o == ctrl_q.last_line);   // Next word is the last
                  end
               end
            ST_WRITING:
               if (wr_valid_i)
               begin
                  if (wr_error)
                  begin
                     state <= ST_ERROR;
                  end
                  else if ((addr_o == ctrl_q.last_line) || wr_eop)
                  begin
                     state <= ST_DONE;
                  end
               end
            default:
            begin
               state <= state;   // Done and error wait for a clear
            end
         endcase
      end
   end

   // Line pointer, ahead of the presented word by one while reading
   always_ff @(posedge clk)
   begin
      case (state)
         ST_IDLE:
            if (go_q)
            begin
               addr_o <= ctrl_q.first_line;
            end
         ST_PRE_READ:
            addr_o <= addr_o + 1'b1;
         ST_READING:
            if (rd_take_i && !rd_eop)
            begin
               addr_o <= addr_o + 1'b1;
            end
         ST_WRITING:
            if (wr_valid_i && !wr_error)
            begin
               addr_o <= addr_o + 1'b1;
            end
         default:
            addr_o <= addr_o;
      endcase
   end

   assign dat_to_buf_o = wr_beat_i.data;
   assign we_o         = (state == ST_WRITING) && wr_valid_i && !wr_error;
   assign en_o         = !((state == ST_READING) && !rd_take_i);   // Hold the presented word
   assign wr_ready_o   = (state == ST_WRITING);

   assign rd_beat_o.data        = dat_from_buf_i;
   assign rd_beat_o.flags.occ   = 2'b00;
   assign rd_beat_o.flags.eop   = rd_eop;
   assign rd_beat_o.flags.sop   = rd_sop;
   assign rd_ready_o            = (state == ST_READING);

   assign status_o.done  = (state == ST_DONE);
   assign status_o.error = (state == ST_ERROR);
   assign status_o.idle  = (state == ST_IDLE);

   assign rd_offset = addr_o - ctrl_q.first_line;
   assign rd_span   = {1'b0, ctrl_q.last_line} - {1'b0, ctrl_q.first_line} + 1'b1;

   // Fetch pointer stays within first line to last line plus one
   a_rd_addr_range: assert property (@(posedge clk) disable iff (rst)
      (state == ST_READING) |-> ({1'b0, rd_offset} <= rd_span));

   a_done_xor_error: assert property (@(posedge clk) disable iff (rst)
      !(status_o.done && status_o.error));

endmodule

//--- logic/stream_switch.sv
// Connects the shared write and read streams to whichever buffer is active
// Buffers must not be reading, or writing, more than one at a time

`include "buffer_pool_params.svh"

module stream_switch
   import buffer_stream_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst,

   // Shared streams
   input  stream_beat_t                     wr_beat_i,
   input  logic                             wr_valid_i,
   output logic                             wr_ready_o,
   output stream_beat_t                     rd_beat_o,
   output logic                             rd_ready_o,
   input  logic                             rd_take_i,

   // Buffer side
   output stream_beat_t                     buf_wr_beat_o,
   output logic         [`BUF_COUNT-1:0]    buf_wr_valid_o,
   input  logic         [`BUF_COUNT-1:0]    buf_wr_ready_i,
   input  stream_beat_t [`BUF_COUNT-1:0]    buf_rd_beat_i,
   input  logic         [`BUF_COUNT-1:0]    buf_rd_ready_i,
   output logic         [`BUF_COUNT-1:0]    buf_rd_take_o
);

   // Write data goes everywhere, valid only to the ready writer
   assign buf_wr_beat_o  = wr_beat_i;
   assign buf_wr_valid_o = buf_wr_ready_i & {`BUF_COUNT{wr_valid_i}};
   assign wr_ready_o     = |buf_wr_ready_i;

   // Take only reaches the buffer presenting a word
   assign buf_rd_take_o = buf_rd_ready_i & {`BUF_COUNT{rd_take_i}};
   assign rd_ready_o    = |buf_rd_ready_i;

   always_comb
   begin
      rd_beat_o = '0;
      for (int i = 0; i < `BUF_COUNT; i++)
      begin
         if (buf_rd_ready_i[i])
         begin
            rd_beat_o = buf_rd_beat_i[i];
         end
      end
   end

   // Host ordering rules
   a_one_reader: assert property (@(posedge clk) disable iff (rst)
      $onehot0(buf_rd_ready_i));

   a_one_writer: assert property (@(posedge clk) disable iff (rst)
      $onehot0(buf_wr_ready_i));

endmodule

//--- logic/buffer_pool.sv
// Top level of the packet buffer pool
// Buffer interface and RAM pairs behind one shared stream switch

`include "buffer_pool_params.svh"

module buffer_pool
   import buffer_ctrl_pkg::*, buffer_stream_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst,

   input  ctrl_word_t                    ctrl_word_i,
   input  logic                          go_i,

   input  stream_beat_t                  wr_beat_i,
   input  logic                          wr_valid_i,
   output logic                          wr_ready_o,

   output stream_beat_t                  rd_beat_o,
   output logic                          rd_ready_o,
   input  logic                          rd_take_i,

   output buf_status_t  [`BUF_COUNT-1:0] status_o
);

   stream_beat_t                  buf_wr_beat;
   logic         [`BUF_COUNT-1:0] buf_wr_valid;
   logic         [`BUF_COUNT-1:0] buf_wr_ready;
   stream_beat_t [`BUF_COUNT-1:0] buf_rd_beat;
   logic         [`BUF_COUNT-1:0] buf_rd_ready;
   logic         [`BUF_COUNT-1:0] buf_rd_take;

   for (genvar i = 0; i < `BUF_COUNT; i++)
   begin : g_buf
      logic               ram_en;
      logic               ram_we;
      logic [`BUF_AW-1:0] ram_addr;
      logic [`BUF_DW-1:0] ram_wdata;
      logic [`BUF_DW-1:0] ram_rdata;

      buffer_int #(
         .BUF_NUM        (i)
      ) i_buffer_int (
         .clk            (clk),
         .rst            (rst),
         .ctrl_word_i    (ctrl_word_i),
         .go_i           (go_i),
         .status_o       (status_o[i]),
         .en_o           (ram_en),
         .we_o           (ram_we),
         .addr_o         (ram_addr),
         .dat_to_buf_o   (ram_wdata),
         .dat_from_buf_i (ram_rdata),
         .wr_beat_i      (buf_wr_beat),
         .wr_valid_i     (buf_wr_valid[i]),
         .wr_ready_o     (buf_wr_ready[i]),
         .rd_beat_o      (buf_rd_beat[i]),
         .rd_ready_o     (buf_rd_ready[i]),
         .rd_take_i      (buf_rd_take[i])
      );

      buffer_ram i_buffer_ram (
         .clk            (clk),
         .en_i           (ram_en),
         .we_i           (ram_we),
         .addr_i         (ram_addr),
         .dat_i          (ram_wdata),
         .dat_o          (ram_rdata)
      );
   end

   stream_switch i_stream_switch (
      .clk            (clk),
      .rst            (rst),
      .wr_beat_i      (wr_beat_i),
      .wr_valid_i     (wr_valid_i),
      .wr_ready_o     (wr_ready_o),
      .rd_beat_o      (rd_beat_o),
      .rd_ready_o     (rd_ready_o),
      .rd_take_i      (rd_take_i),
      .buf_wr_beat_o  (buf_wr_beat),
      .buf_wr_valid_o (buf_wr_valid),
      .buf_wr_ready_i (buf_wr_ready),
      .buf_rd_beat_i  (buf_rd_beat),
      .buf_rd_ready_i (buf_rd_ready),
      .buf_rd_take_o  (buf_rd_take)
   );

endmodule

//--- verification/buffer_pool_checks.svh
// Typed compare tasks and error counting for the buffer pool testbench
// Included inside the testbench module, after the package imports

`ifndef BUFFER_POOL_CHECKS_SVH
`define BUFFER_POOL_CHECKS_SVH

int error_count = 0;
int check_count = 0;

// One stream word, data and flags together
task automatic check_beat(input stream_beat_t got, input stream_beat_t expected,
                          input string what);
   check_count++;
   if (got !== expected)
   begin
      error_count++;
      $display("Error at time %0t: %s, got data %h flags %b, expected data %h flags %b",
               $time, what, got.data, got.flags, expected.data, expected.flags);
   end
endtask

// Done, error and idle of one buffer
task automatic check_status(input buf_status_t got, input buf_status_t expected,
                            input string what);
   check_count++;
   if (got !== expected)
   begin
      error_count++;
      $display("Error at time %0t: %s, got status %b, expected %b (done error idle)",
               $time, what, got, expected);
   end
endtask

task automatic check_ready(input logic got, input logic expected, input string what);
   check_count++;
   if (got !== expected)
   begin
      error_count++;
      $display("Error at time %0t: %s, got %b, expected %b", $time, what, got, expected);
   end
endtask

`endif

//--- verification/buffer_pool_tb.sv
// Self-checking testbench for the buffer pool with random packets against a line model
// Compile with filelist.f with buffer_pool_tb as the top module

`include "buffer_pool_params.svh"

module buffer_pool_tb
   import buffer_ctrl_pkg::*, buffer_stream_pkg::*;
();

   localparam buf_status_t STATUS_IDLE  = 3'b001;   // Bits are done, error, idle
   localparam buf_status_t STATUS_ERROR = 3'b010;
   localparam buf_status_t STATUS_DONE  = 3'b100;

   logic                         clk;
   logic                         rst;
   ctrl_word_t                   ctrl_word;
   logic                         go;
   stream_beat_t                 wr_beat;
   logic                         wr_valid;
   logic                         wr_ready;
   stream_beat_t                 rd_beat;
   logic                         rd_ready;
   logic                         rd_take;
   buf_status_t [`BUF_COUNT-1:0] status;

   logic [31:0]        rng_state;
   logic [`BUF_DW-1:0] model [`BUF_COUNT][1 << `BUF_AW];   // Last word written per line
   int                 first_line [`BUF_COUNT];
   int                 last_line [`BUF_COUNT];
   int                 eop_pos [`BUF_COUNT];
   int                 cycle_count = 0;
   int                 cycle_limit = 200;
   int                 test_count = 0;
   int                 fail_count = 0;
   int                 errors_seen = 0;

   `include "buffer_pool_checks.svh"

   buffer_pool i_dut (
      .clk         (clk),
      .rst         (rst),
      .ctrl_word_i (ctrl_word),
      .go_i        (go),
      .wr_beat_i   (wr_beat),
      .wr_valid_i  (wr_valid),
      .wr_ready_o  (wr_ready),
      .rd_beat_o   (rd_beat),
      .rd_ready_o  (rd_ready),
      .rd_take_i   (rd_take),
      .status_o    (status)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // One go pulse that returns on the falling edge after it
   task automatic send_ctrl(input int b, input logic clr, input logic wr, input logic rd,
                            input int first, input int last);
      ctrl_word_t cw;
      cw            = '0;
      cw.buf_num    = b[3:0];
      cw.port       = 3'(next_random());   // Ignored by the pool
      cw.clear      = clr;
      cw.write      = wr;
      cw.read       = rd;
      cw.last_line  = last[`BUF_AW-1:0];
      cw.first_line = first[`BUF_AW-1:0];
      @(negedge clk);
      ctrl_word = cw;
      go        = 1'b1;
      @(negedge clk);
      go = 1'b0;
   endtask

   task automatic clear_buffer(input int b);
      send_ctrl(b, 1'b1, 1'b0, 1'b0, 0, 0);
      @(negedge clk);   // Idle one cycle after go
      check_status(status[b], STATUS_IDLE, $sformatf("buffer %0d after clear", b));
   endtask

   // Offer words with random gaps until the packet ends
   // An index of -1 turns off the eop or error word
   task automatic write_packet(input int b, input int first, input int last,
                               input int eop_at, input int err_at);
      stream_beat_t beat;
      logic [31:0]  r;
      int           k;
      bit           finished;
      k        = 0;
      finished = 1'b0;
      send_ctrl(b, 1'b0, 1'b1, 1'b0, first, last);
      while (!finished)
      begin
         @(negedge clk);
         r        = next_random();
         wr_valid = 1'b0;
         if (wr_ready && r[1:0] != 2'b00)
         begin
            beat.data      = next_random();
            beat.flags.occ = r[5:4];
            beat.flags.sop = (k == 0) || (k == err_at);
            beat.flags.eop = (k == eop_at) || (k == err_at);
            wr_beat  = beat;
            wr_valid = 1'b1;
            if (k != err_at)
            begin
               model[b][first + k] = beat.data;
            end
            finished = (k == last - first) || (k == eop_at) || (k == err_at);
            k++;
         end
      end
      @(negedge clk);
      wr_valid = 1'b0;
   endtask

   // Takes words with random back-pressure and optionally checks when the first appears
   task automatic read_packet(input int b, input int first, input int last,
                              input bit check_timing);
      stream_beat_t expected;
      logic [31:0]  r;
      int           line;
      line = first;
      send_ctrl(b, 1'b0, 1'b0, 1'b1, first, last);
      @(negedge clk);
      if (check_timing)
      begin
         check_ready(rd_ready, 1'b0, "read ready 2 cycles after go");
         @(negedge clk);
         check_ready(rd_ready, 1'b1, "read ready 3 cycles after go");
      end
      while (line <= last)
      begin
         r       = next_random();
         rd_take = 1'b0;
         if (rd_ready && r[1:0] != 2'b00)
         begin
            expected.data      = model[b][line];
            expected.flags.occ = 2'b00;
            expected.flags.sop = (line == first);
            expected.flags.eop = (line == last);
            check_beat(rd_beat, expected, $sformatf("buffer %0d line %0d", b, line));
            rd_take = 1'b1;
            line++;
         end
         @(negedge clk);
      end
      rd_take = 1'b0;
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (error_count == errors_seen)
      begin
         $display("Test %0d %s: pass", test_count, name);
      end
      else
      begin
         fail_count++;
         $display("Test %0d %s: fail with %0d errors", test_count, name,
                  error_count - errors_seen);
      end
      errors_seen = error_count;
   endtask

   initial
   begin
      rng_state = 32'hf9f85de3;
      rst       = 1'b1;
      go        = 1'b0;
      ctrl_word = '0;
      wr_beat   = '0;
      wr_valid  = 1'b0;
      rd_take   = 1'b0;

      // Packets of 3 to 40 lines with eop strictly inside the packet
      for (int b = 0; b < `BUF_COUNT; b++)
      begin
         first_line[b] = int'(next_random() % 472);
         last_line[b]  = first_line[b] + 2 + int'(next_random() % 38);
         eop_pos[b]    = 1 + int'(next_random() % (last_line[b] - first_line[b] - 1));
         cycle_limit  += 20 * (3 * (last_line[b] - first_line[b] + 1) + eop_pos[b] + 1);
      end
      cycle_limit += 20 * (3 + last_line[1] - first_line[1] + 1);

      repeat (2) @(negedge clk);
      rst = 1'b0;

      for (int b = 0; b < `BUF_COUNT; b++)
      begin
         check_status(status[b], STATUS_IDLE, $sformatf("buffer %0d after reset", b));
      end
      check_ready(wr_ready, 1'b0, "write ready after reset");
      check_ready(rd_ready, 1'b0, "read ready after reset");
      end_test("after reset");

      for (int b = 0; b < `BUF_COUNT; b++)
      begin
         write_packet(b, first_line[b], last_line[b], -1, -1);
         check_status(status[b], STATUS_DONE, $sformatf("buffer %0d full write", b));
         clear_buffer(b);
         read_packet(b, first_line[b], last_line[b], 1'b0);
         check_status(status[b], STATUS_DONE, $sformatf("buffer %0d read back", b));
         clear_buffer(b);
      end
      end_test("full write then read");

      for (int b = 0; b < `BUF_COUNT; b++)
      begin
         write_packet(b, first_line[b], last_line[b], eop_pos[b], -1);
         check_status(status[b], STATUS_DONE, $sformatf("buffer %0d early eop", b));
         check_ready(wr_ready, 1'b0, "write ready after early eop");
         clear_buffer(b);
         read_packet(b, first_line[b], last_line[b], 1'b0);
         check_status(status[b], STATUS_DONE, $sformatf("buffer %0d read after eop", b));
      end
      end_test("early end of write");

      clear_buffer(0);
      write_packet(0, first_line[0], last_line[0], -1, 2);   // Third word is malformed
      check_status(status[0], STATUS_ERROR, "buffer 0 after sop and eop word");
      check_ready(wr_ready, 1'b0, "write ready in error");
      end_test("write error");

      clear_buffer(0);
      check_status(status[1], STATUS_DONE, "buffer 1 while buffer 0 clears");
      clear_buffer(1);
      check_status(status[0], STATUS_IDLE, "buffer 0 while buffer 1 clears");
      end_test("clear");

      read_packet(1, first_line[1], last_line[1], 1'b1);
      check_status(status[1], STATUS_DONE, "buffer 1 timed read");
      clear_buffer(1);
      end_test("read timing");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               test_count, fail_count, check_count, error_count);
      if (error_count == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+include
+incdir+verification
logic/buffer_ctrl_pkg.sv
logic/buffer_stream_pkg.sv
logic/buffer_ram.sv
logic/buffer_int.sv
logic/stream_switch.sv
logic/buffer_pool.sv
verification/buffer_pool_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the buffer pool testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module buffer_pool_tb \
   -o sim_buffer_pool
./obj_dir/sim_buffer_pool > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0
